// ==== compile.f ====
+incdir+include
logic/lsu_pkg.sv
logic/bus_pkg.sv
logic/lsu_ctrl_fsm.sv
logic/lsu_store_align.sv
logic/lsu_load_align.sv
logic/lsu_top.sv
testbench/lsu_props.sv
testbench/lsu_mem_model.sv
testbench/lsu_tb.sv

// ==== testbench/lsu_tb.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit testbench
// directed and random accesses against a shadow memory, checked by
// concurrent assertions on the core response and the bus requests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_tb
  import lsu_pkg::*;
  import bus_pkg::*;
();

  localparam int CLK_PERIOD     = 100;
  localparam int RST_CYCLES     = 8;
  localparam int N_RANDOM       = 240;
  localparam int TIMEOUT_CYCLES = 300 * 25; // accesses times worst-case cycles each
  localparam int ERR_LO         = 'hF0;     // error window, bytes 0x3c0..0x3cf
  localparam int ERR_HI         = 'hF3;

  typedef struct packed {
    lsu_resp_t resp;
    logic      chk_rdata;    // loads without error
    logic      chk_err_addr; // accesses with error
  } exp_resp_t;

  typedef struct packed {
    bus_req_t req;
    logic     chk_wr;        // enables and data matter for stores only
  } exp_bus_t;

  logic        clk;
  logic        rst_n;
  logic        lsu_req_valid;
  lsu_req_t    lsu_req;
  logic        lsu_resp_valid;
  lsu_resp_t   lsu_resp;
  logic        lsu_busy;
  logic        data_req;
  bus_req_t    data_req_bus;
  logic        data_gnt;
  logic        data_rvalid;
  bus_rsp_t    data_rsp;

  logic [7:0]  shadow [0:1023]; // byte image of the model memory
  exp_resp_t   resp_q [$];
  exp_bus_t    bus_q [$];
  exp_resp_t   resp_head;
  exp_bus_t    bus_head;
  logic        resp_head_vld;
  logic        bus_head_vld;
  int unsigned resp_errs;
  int unsigned bus_errs;
  int unsigned cycles;
  integer      seed;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  lsu_top dut0 (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .lsu_req_valid_i  (lsu_req_valid),
    .lsu_req_i        (lsu_req),
    .lsu_resp_valid_o (lsu_resp_valid),
    .lsu_resp_o       (lsu_resp),
    .lsu_busy_o       (lsu_busy),
    .data_req_o       (data_req),
    .data_req_o_bus   (data_req_bus),
    .data_gnt_i       (data_gnt),
    .data_rvalid_i    (data_rvalid),
    .data_rsp_i       (data_rsp)
  );

  lsu_mem_model #(.ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) mem0 (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .req_i     (data_req),
    .req_bus_i (data_req_bus),
    .gnt_o     (data_gnt),
    .rvalid_o  (data_rvalid),
    .rsp_o     (data_rsp)
  );

  //////////////////////////////////////////////////////////////////////
  // expected values from the access rules
  //////////////////////////////////////////////////////////////////////

  function automatic logic in_window(logic [31:0] a);
    return (a[9:2] >= ERR_LO) && (a[9:2] <= ERR_HI);
  endfunction

  function automatic int size_bytes(lsu_size_e s);
    case (s)
      LSU_SIZE_WORD: return 4;
      LSU_SIZE_HALF: return 2;
      default:       return 1;
    endcase
  endfunction

  // queue the expected bus parts and response, then run one access
  task automatic issue(input logic we, input lsu_size_e size, input logic sign,
                       input logic [31:0] addr, input logic [31:0] wdata);
    int          n;
    int          off;
    logic        split;
    logic        e_lo;
    logic        e_hi;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] ld;
    exp_bus_t    eb;
    exp_resp_t   er;
    n     = size_bytes(size);
    off   = addr[1:0];
    lo    = {addr[31:2], 2'b00};
    hi    = lo + 32'd4;
    split = (off + n > 4); // access runs past the end of its word
    e_lo  = in_window(lo);
    e_hi  = split && in_window(hi);
    for (int p = 0; p < (split ? 2 : 1); p++) begin
      eb.req.addr = (p == 1) ? hi : lo;
      eb.req.we   = we;
      eb.chk_wr   = we;
      for (int i = 0; i < 4; i++) begin
        eb.req.be[i] = (i + 4*p >= off) && (i + 4*p < off + n); // lane holds an access byte
        eb.req.wdata[8*i +: 8] = wdata[8*((i - off) & 3) +: 8];   // rotate left by offset
      end
      bus_q.push_back(eb);
    end
    ld = '0;
    for (int k = 0; k < n; k++) begin
      ld[8*k +: 8] = shadow[(addr + k) & 32'h3FF]; // little endian
    end
    for (int k = n; k < 4; k++) begin
      ld[8*k +: 8] = {8{sign & ld[8*n-1]}};
    end
    er.resp.rdata     = ld;
    er.resp.load_err  = !we && (e_lo || e_hi);
    er.resp.store_err = we && (e_lo || e_hi);
    er.resp.err_addr  = e_lo ? addr : hi;
    er.chk_rdata      = !we && !(e_lo || e_hi);
    er.chk_err_addr   = e_lo || e_hi;
    resp_q.push_back(er);
    for (int k = 0; k < n; k++) begin
      if (we && !in_window(addr + k)) begin
        shadow[(addr + k) & 32'h3FF] = wdata[8*k +: 8];
      end
    end
    lsu_req.we       = we;
    lsu_req.size     = size;
    lsu_req.sign_ext = sign;
    lsu_req.addr     = addr;
    lsu_req.wdata    = wdata;
    lsu_req_valid    = 1'b1;
    @(negedge clk);
    lsu_req_valid = 1'b0;
    while (lsu_busy) begin
      @(negedge clk); // busy falls the cycle after the response
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // queue heads and checks
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    resp_head_vld = (resp_q.size() != 0);
    bus_head_vld  = (bus_q.size() != 0);
    if (resp_head_vld) resp_head = resp_q[0];
    if (bus_head_vld) bus_head = bus_q[0];
  end

  always @(posedge clk) begin
    if (lsu_resp_valid && resp_q.size() != 0) void'(resp_q.pop_front());
    if (data_req && data_gnt && bus_q.size() != 0) void'(bus_q.pop_front());
  end

  resp_expected_a: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_resp_valid |-> resp_head_vld)
    else begin
      resp_errs++;
      $display("core response at %0t with no access waiting for one", $time);
    end

  rdata_a: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_resp_valid && resp_head_vld && resp_head.chk_rdata) |->
      (lsu_resp.rdata == resp_head.resp.rdata))
    else begin
      resp_errs++;
      $display("FAIL %0t: load data %h, expected %h", $time,
               $sampled(lsu_resp.rdata), $sampled(resp_head.resp.rdata));
    end

  err_flags_a: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_resp_valid && resp_head_vld) |->
      (lsu_resp.load_err == resp_head.resp.load_err &&
       lsu_resp.store_err == resp_head.resp.store_err))
    else begin
      resp_errs++;
      $display("FAIL %0t: load/store error flags %b%b, expected %b%b", $time,
               $sampled(lsu_resp.load_err), $sampled(lsu_resp.store_err),
               $sampled(resp_head.resp.load_err), $sampled(resp_head.resp.store_err));
    end

  err_addr_a: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_resp_valid && resp_head_vld && resp_head.chk_err_addr) |->
      (lsu_resp.err_addr == resp_head.resp.err_addr))
    else begin
      resp_errs++;
      $display("FAIL %0t: error address %h, expected %h", $time,
               $sampled(lsu_resp.err_addr), $sampled(resp_head.resp.err_addr));
    end

  bus_expected_a: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req && data_gnt) |-> bus_head_vld)
    else begin
      bus_errs++;
      $display("bus request granted at %0t that no access asked for", $time);
    end

  bus_addr_a: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req && data_gnt && bus_head_vld) |->
      (data_req_bus.addr == bus_head.req.addr && data_req_bus.we == bus_head.req.we))
    else begin
      bus_errs++;
      $display("FAIL %0t: bus address %h we %b, expected %h we %b", $time,
               $sampled(data_req_bus.addr), $sampled(data_req_bus.we),
               $sampled(bus_head.req.addr), $sampled(bus_head.req.we));
    end

  bus_wr_a: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req && data_gnt && bus_head_vld && bus_head.chk_wr) |->
      (data_req_bus.be == bus_head.req.be && data_req_bus.wdata == bus_head.req.wdata))
    else begin
      bus_errs++;
      $display("FAIL %0t: store be %b data %h, expected be %b data %h", $time,
               $sampled(data_req_bus.be), $sampled(data_req_bus.wdata),
               $sampled(bus_head.req.be), $sampled(bus_head.req.wdata));
    end

  // first bus request and busy exactly one cycle after the strobe
  req_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_req_valid |=> (data_req && lsu_busy))
    else begin
      bus_errs++;
      $display("no bus request or busy in the cycle after the core strobe at %0t", $time);
    end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] w;
    logic [31:0] r;
    int unsigned prop_errs;
    seed          = 32'h984035bf;
    rst_n         = 1'b0;
    lsu_req_valid = 1'b0;
    lsu_req       = '0;
    resp_errs     = 0;
    bus_errs      = 0;
    cycles        = 0;
    resp_head_vld = 1'b0;
    bus_head_vld  = 1'b0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < 256; i++) begin
      for (int b = 0; b < 4; b++) begin
        shadow[4*i + b] = mem0.mem[i][8*b +: 8]; // model's random start contents
      end
    end

    // aligned word store then load
    for (int i = 0; i < 4; i++) begin
      w = $random(seed);
      issue(1'b1, LSU_SIZE_WORD, 1'b0, 32'h040 + 4*i, w);
      issue(1'b0, LSU_SIZE_WORD, 1'b0, 32'h040 + 4*i, '0);
    end

    // byte and half loads, every offset, both sign modes, both sign bit values
    issue(1'b1, LSU_SIZE_WORD, 1'b0, 32'h100, 32'h80ff7f01);
    issue(1'b1, LSU_SIZE_WORD, 1'b0, 32'h104, 32'h7f0180fe);
    for (int a = 0; a < 8; a++) begin
      for (int s = 0; s < 2; s++) begin
        issue(1'b0, LSU_SIZE_BYTE, s[0], 32'h100 + a, '0);
        issue(1'b0, LSU_SIZE_HALF, s[0], 32'h100 + a, '0);
      end
    end

    // split words at each offset and split half
    for (int o = 1; o < 4; o++) begin
      w = $random(seed);
      issue(1'b1, LSU_SIZE_WORD, 1'b0, 32'h200 + 16*o + o, w);
      issue(1'b0, LSU_SIZE_WORD, 1'b0, 32'h200 + 16*o + o, '0);
    end
    issue(1'b1, LSU_SIZE_HALF, 1'b0, 32'h243, 32'h0000_8a5c);
    issue(1'b0, LSU_SIZE_HALF, 1'b1, 32'h243, '0);

    // error window, whole access, upper part only, lower part only
    issue(1'b0, LSU_SIZE_WORD, 1'b0, 32'h3c4, '0);
    issue(1'b1, LSU_SIZE_BYTE, 1'b0, 32'h3c9, 32'h0000_00a5);
    issue(1'b0, LSU_SIZE_WORD, 1'b0, 32'h3bf, '0);
    issue(1'b1, LSU_SIZE_WORD, 1'b0, 32'h3bd, 32'h1234_5678);
    issue(1'b1, LSU_SIZE_HALF, 1'b0, 32'h3cf, 32'h0000_beef);
    issue(1'b0, LSU_SIZE_HALF, 1'b1, 32'h3cf, '0);

    // random mix over the whole 1 KB
    for (int i = 0; i < N_RANDOM; i++) begin
      r = $random(seed);
      w = $random(seed);
      issue(r[0], lsu_size_e'((r[2:1] == 2'b11) ? 2'b00 : r[2:1]), r[3],
            {22'h0, r[13:4]}, w);
    end

    repeat (2) @(negedge clk);
    if (resp_q.size() != 0 || bus_q.size() != 0) begin
      resp_errs++;
      $display("expected responses or bus requests never arrived");
    end
    prop_errs = dut0.props0.fail_cnt;
    $display("errors: response %0d, bus %0d, protocol %0d", resp_errs, bus_errs, prop_errs);
    if (resp_errs + bus_errs + prop_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/lsu_mem_model.sv ====
//////////////////////////////////////////////////////////////////////
// data bus memory model
// random grant stalls, in-order responses with random latency,
// error window that rejects accesses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lsu_mem_model
  import bus_pkg::*;
#(
  parameter int ERR_LO = 'hF0, // first word index of the error window
  parameter int ERR_HI = 'hF3  // last word index of the error window
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,
  input  bus_req_t req_bus_i,
  output logic     gnt_o,
  output logic     rvalid_o,
  output bus_rsp_t rsp_o
);

  typedef struct packed {
    bus_rsp_t    rsp;
    int unsigned due; // cycle from which the response may go out
  } pend_t;

  bus_data_t   mem [0:255];  // 1 KB, upper address bits alias
  pend_t       pend_q [$];   // granted, not yet answered
  pend_t       head;
  pend_t       entry;
  integer      seed;
  int unsigned cyc;
  int unsigned stall;        // request cycles left before the next grant
  logic [7:0]  widx;

  initial begin
    seed     = 32'h984035bf;
    cyc      = 0;
    stall    = 0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rsp_o    = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = $random(seed);
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk_i) begin
    cyc      = cyc + 1;
    rvalid_o = 1'b0;
    if (!rst_ni) begin
      gnt_o = 1'b0;
    end else begin
      if (req_i && stall != 0) begin
        stall = stall - 1;
        gnt_o = 1'b0;
      end else begin
        gnt_o = req_i;
      end
      if (pend_q.size() != 0 && pend_q[0].due <= cyc) begin
        head     = pend_q.pop_front();
        rvalid_o = 1'b1;
        rsp_o    = head.rsp;
      end
    end
  end

  // accepted request: read or write at grant time
  always @(posedge clk_i) begin
    if (rst_ni && req_i && gnt_o) begin
      widx      = req_bus_i.addr[9:2];
      entry.due = cyc + 1 + ($unsigned($random(seed)) % 3); // latency 1..3
      if (widx >= ERR_LO && widx <= ERR_HI) begin
        entry.rsp.err   = 1'b1;
        entry.rsp.rdata = '0;
      end else begin
        entry.rsp.err   = 1'b0;
        entry.rsp.rdata = mem[widx];
        for (int b = 0; b < 4; b++) begin
          if (req_bus_i.we && req_bus_i.be[b]) begin
            mem[widx][8*b +: 8] = req_bus_i.wdata[8*b +: 8];
          end
        end
      end
      pend_q.push_back(entry);
      stall = $unsigned($random(seed)) % 4; // 0..3 stall cycles
    end
  end

endmodule

`default_nettype wire

// ==== testbench/lsu_props.sv ====
//////////////////////////////////////////////////////////////////////
// data bus protocol properties, bound into the load/store unit top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_props
  import bus_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input logic     data_req_o,
  input bus_req_t data_req_o_bus,
  input logic     data_gnt_i,
  input logic     data_rvalid_i,
  input logic     lsu_resp_valid_o,
  input logic     lsu_busy_o
);

  int unsigned fail_cnt = 0; // failed property checks
  logic [2:0]  outstanding_q; // granted, waiting for rvalid

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(data_req_o & data_gnt_i) - 3'(data_rvalid_i);
    end
  end

  // word aligned, and at least one lane enabled for every part
  aligned_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_req_o_bus.addr[1:0] == 2'b00 && data_req_o_bus.be != '0))
    else begin
      fail_cnt++;
      $error("bus request address is not word aligned or enables no byte");
    end

  // request and payload hold until granted
  stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_req_o_bus)))
    else begin
      fail_cnt++;
      $error("bus request dropped or changed before grant");
    end

  // busy covers the response cycle and drops right after it
  resp_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_resp_valid_o |-> lsu_busy_o ##1 !lsu_busy_o)
    else begin
      fail_cnt++;
      $error("busy did not cover the core response or stayed high after it");
    end

  outstanding_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_q <= `LSU_MAX_OUTSTANDING)
    else begin
      fail_cnt++;
      $error("more bus transactions in flight than allowed");
    end

endmodule

bind lsu_top lsu_props props0 (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .data_req_o       (data_req_o),
  .data_req_o_bus   (data_req_o_bus),
  .data_gnt_i       (data_gnt_i),
  .data_rvalid_i    (data_rvalid_i),
  .lsu_resp_valid_o (lsu_resp_valid_o),
  .lsu_busy_o       (lsu_busy_o)
);

`default_nettype wire

// ==== logic/lsu_top.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit top level
// core strobe interface in, request/grant/rvalid data bus out
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_top
  import lsu_pkg::*;
  import bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // core side
  input  logic      lsu_req_valid_i,
  input  lsu_req_t  lsu_req_i,
  output logic      lsu_resp_valid_o,
  output lsu_resp_t lsu_resp_o,
  output logic      lsu_busy_o,
  // data bus
  output logic      data_req_o,
  output bus_req_t  data_req_o_bus,
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  input  bus_rsp_t  data_rsp_i
);

  lsu_req_t               acc_q;          // access held by the control block
  logic                   second_part;
  logic                   rdata_capture;
  logic                   data_we;
  logic                   load_err;
  logic                   store_err;
  logic [`LSU_ADDR_W-1:0] data_addr;
  logic [`LSU_ADDR_W-1:0] err_addr;
  logic [`LSU_BE_W-1:0]   data_be;
  logic [`LSU_DATA_W-1:0] data_wdata;
  logic [`LSU_DATA_W-1:0] rdata;

  lsu_ctrl_fsm u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (lsu_req_valid_i),
    .req_i           (lsu_req_i),
    .data_req_o      (data_req_o),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_err_i      (data_rsp_i.err),
    .data_addr_o     (data_addr),
    .data_we_o       (data_we),
    .second_part_o   (second_part),
    .acc_q_o         (acc_q),
    .rdata_capture_o (rdata_capture),
    .resp_valid_o    (lsu_resp_valid_o),
    .load_err_o      (load_err),
    .store_err_o     (store_err),
    .err_addr_o      (err_addr),
    .busy_o          (lsu_busy_o)
  );

  lsu_store_align u_store_align (
    .size_i        (acc_q.size),
    .offset_i      (acc_q.addr[1:0]),
    .second_part_i (second_part),
    .wdata_i       (acc_q.wdata),
    .be_o          (data_be),
    .wdata_o       (data_wdata)
  );

  lsu_load_align u_load_align (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .capture_i  (rdata_capture),
    .size_i     (acc_q.size),
    .offset_i   (acc_q.addr[1:0]),
    .sign_ext_i (acc_q.sign_ext),
    .rdata_i    (data_rsp_i.rdata), // last response feeds the result directly
    .rdata_o    (rdata)
  );

  // pack bus request and core response
  assign data_req_o_bus = '{addr: data_addr, we: data_we, be: data_be, wdata: data_wdata};

  assign lsu_resp_o = '{rdata:     rdata,
                        load_err:  load_err,
                        store_err: store_err,
                        err_addr:  err_addr};

endmodule

`default_nettype wire

// ==== logic/lsu_load_align.sv ====
//////////////////////////////////////////////////////////////////////
// load alignment
// keeps the lower word of a split load, reassembles the result and
// applies zero or sign extension
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   capture_i,  // lower word of a split load returns
  input  lsu_size_e              size_i,
  input  logic [1:0]             offset_i,
  input  logic                   sign_ext_i,
  input  logic [`LSU_DATA_W-1:0] rdata_i,    // current bus response data
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  logic [`LSU_DATA_W-1:8]  first_q;   // upper three bytes of the lower word
  logic [`LSU_DATA_W-1:0]  word_al;   // realigned word
  logic [15:0]             half_al;
  logic [7:0]              byte_al;
  logic [4:0]              bit_off;

  assign bit_off = {offset_i, 3'b000};

  // byte 0 of the lower word is never part of a split result
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q <= '0;
    end else if (capture_i) begin
      first_q <= rdata_i[`LSU_DATA_W-1:8];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////////////////////////

  // unaligned words continue into the low bytes of the upper word
  always_comb begin
    unique case (offset_i)
      2'b00:   word_al = rdata_i;
      2'b01:   word_al = {rdata_i[7:0],  first_q[`LSU_DATA_W-1:8]};
      2'b10:   word_al = {rdata_i[15:0], first_q[`LSU_DATA_W-1:16]};
      2'b11:   word_al = {rdata_i[23:0], first_q[`LSU_DATA_W-1:24]};
      default: word_al = rdata_i;
    endcase
  end

  // half word at offset 3 is the only split half
  always_comb begin
    if (offset_i == 2'b11) begin
      half_al = {rdata_i[7:0], first_q[`LSU_DATA_W-1:24]};
    end else begin
      half_al = rdata_i[bit_off +: 16];
    end
  end

  assign byte_al = rdata_i[bit_off +: 8]; // bytes never split

  //////////////////////////////////////////////////////////////////////
  // extension
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (size_i)
      LSU_SIZE_WORD: rdata_o = word_al;
      LSU_SIZE_HALF: rdata_o = {{(`LSU_DATA_W-16){sign_ext_i & half_al[15]}}, half_al};
      LSU_SIZE_BYTE: rdata_o = {{(`LSU_DATA_W-8){sign_ext_i & byte_al[7]}}, byte_al};
      default:       rdata_o = word_al;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/lsu_store_align.sv ====
//////////////////////////////////////////////////////////////////////
// store alignment
// byte enables and write-data lane rotation for each bus part
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_store_align
  import lsu_pkg::*;
  import bus_pkg::*;
(
  input  lsu_size_e              size_i,
  input  logic [1:0]             offset_i,      // byte offset of the access
  input  logic                   second_part_i, // upper word of a split access
  input  logic [`LSU_DATA_W-1:0] wdata_i,       // right aligned from the core
  output logic [`LSU_BE_W-1:0]   be_o,
  output logic [`LSU_DATA_W-1:0] wdata_o
);

  bus_be_t                    base_be;   // enables for an aligned access of this size
  logic [2*`LSU_BE_W-1:0]     be_wide;   // enables across both words
  logic [2*`LSU_DATA_W-1:0]   wdata_wide;
  bus_data_t                  wdata_rot;

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (size_i)
      LSU_SIZE_WORD: base_be = '1;
      LSU_SIZE_HALF: base_be = bus_be_t'(2'b11);
      LSU_SIZE_BYTE: base_be = bus_be_t'(1'b1);
      default:       base_be = '1;
    endcase
  end

  // shifting by the offset spills the high bytes into the next word
  assign be_wide = {{`LSU_BE_W{1'b0}}, base_be} << offset_i;

  // first part gets offset upward, clipped; second part the spilled low bytes
  assign be_o = second_part_i ? be_wide[2*`LSU_BE_W-1:`LSU_BE_W]
                              : be_wide[`LSU_BE_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // write data
  //////////////////////////////////////////////////////////////////////

  // rotate left by the byte offset, same lanes serve both parts
  assign wdata_wide = {wdata_i, wdata_i} << {offset_i, 3'b000};
  assign wdata_rot  = wdata_wide[2*`LSU_DATA_W-1:`LSU_DATA_W];
  assign wdata_o    = wdata_rot;

endmodule

`default_nettype wire

// ==== logic/lsu_ctrl_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// load/store access control
// holds the access, splits unaligned parts into two word requests,
// tracks responses and errors, strobes the core response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_ctrl_fsm
  import lsu_pkg::*;
  import bus_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // core side
  input  logic                   req_valid_i,   // one-cycle strobe, only while idle
  input  lsu_req_t               req_i,
  // bus handshake
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  output logic [`LSU_ADDR_W-1:0] data_addr_o,   // word aligned
  output logic                   data_we_o,
  // to the alignment blocks
  output logic                   second_part_o, // request in flight is the upper word
  output lsu_req_t               acc_q_o,
  output logic                   rdata_capture_o,
  // response
  output logic                   resp_valid_o,
  output logic                   load_err_o,
  output logic                   store_err_o,
  output logic [`LSU_ADDR_W-1:0] err_addr_o,
  output logic                   busy_o
);

  lsu_state_e state_q, state_d;

  lsu_req_t               acc_q;        // accepted access
  logic                   first_err_q;  // first part of a split came back with error
  logic [`LSU_ADDR_W-1:0] err_addr_q;   // address reported on error
  bus_addr_t              addr_lo;      // word holding the first byte
  bus_addr_t              addr_hi;      // following word, split accesses only
  logic                   split_req;
  logic                   split_acc;
  logic                   accept;
  logic                   first_rvalid; // response to the lower word of a split

  // word that is not word aligned, or half word crossing into the next word
  function automatic logic is_split(lsu_size_e size, logic [1:0] offset);
    return ((size == LSU_SIZE_WORD) && (offset != 2'b00)) ||
           ((size == LSU_SIZE_HALF) && (offset == 2'b11));
  endfunction

  assign split_req = is_split(req_i.size, req_i.addr[1:0]);
  assign split_acc = is_split(acc_q.size, acc_q.addr[1:0]);
  assign accept    = req_valid_i & (state_q == ST_IDLE);

  assign addr_lo = {acc_q.addr[`LSU_ADDR_W-1:2], 2'b00};
  assign addr_hi = addr_lo + bus_addr_t'(4);

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    data_req_o    = 1'b0;
    second_part_o = 1'b0;
    first_rvalid  = 1'b0;
    resp_valid_o  = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        if (req_valid_i) begin
          state_d = split_req ? ST_WAIT_GNT_SPLIT : ST_WAIT_GNT;
        end
      end

      ST_WAIT_GNT_SPLIT: begin
        data_req_o = 1'b1; // lower word
        if (data_gnt_i) begin
          state_d = ST_WAIT_RVALID_SPLIT;
        end
      end

      ST_WAIT_RVALID_SPLIT: begin
        // upper word goes out while the lower one is still outstanding
        data_req_o    = 1'b1;
        second_part_o = 1'b1;
        first_rvalid  = data_rvalid_i;
        if (data_rvalid_i) begin
          state_d = data_gnt_i ? ST_WAIT_RVALID : ST_WAIT_GNT;
        end else if (data_gnt_i) begin
          state_d = ST_WAIT_RVALID_SPLIT_GNTS_DONE; // two in flight
        end
      end

      ST_WAIT_GNT: begin
        data_req_o    = 1'b1;
        second_part_o = split_acc; // upper word after the lower one returned
        if (data_gnt_i) begin
          state_d = ST_WAIT_RVALID;
        end
      end

      ST_WAIT_RVALID_SPLIT_GNTS_DONE: begin
        first_rvalid = data_rvalid_i;
        if (data_rvalid_i) begin
          state_d = ST_WAIT_RVALID;
        end
      end

      ST_WAIT_RVALID: begin
        resp_valid_o = data_rvalid_i; // same cycle as the last rvalid
        if (data_rvalid_i) begin
          state_d = ST_IDLE;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ST_IDLE;
      first_err_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        first_err_q <= 1'b0;
      end else if (first_rvalid) begin
        first_err_q <= data_err_i;
      end
    end
  end

  // access payload and error address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      acc_q      <= req_i;
      err_addr_q <= req_i.addr;  // first part address
    end else if (first_rvalid && !data_err_i) begin
      err_addr_q <= addr_hi;     // lower word fine, upper word may still fail
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////

  assign data_addr_o     = second_part_o ? addr_hi : addr_lo;
  assign data_we_o       = acc_q.we;
  assign acc_q_o         = acc_q;
  assign rdata_capture_o = first_rvalid & ~acc_q.we; // loads keep the lower word

  // error of either part ends up on the single response
  assign load_err_o  = resp_valid_o & ~acc_q.we & (first_err_q | data_err_i);
  assign store_err_o = resp_valid_o &  acc_q.we & (first_err_q | data_err_i);
  assign err_addr_o  = err_addr_q;

  assign busy_o = (state_q != ST_IDLE);

endmodule

`default_nettype wire

// ==== logic/bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// data bus types
// word-aligned request and single-beat response
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "lsu_settings.svh"

package bus_pkg;

  typedef logic [`LSU_ADDR_W-1:0] bus_addr_t;
  typedef logic [`LSU_BE_W-1:0]   bus_be_t;
  typedef logic [`LSU_DATA_W-1:0] bus_data_t;

  // request, held stable until granted (69 bits)
  typedef struct packed {
    bus_addr_t addr;  // low two bits always zero
    logic      we;
    bus_be_t   be;
    bus_data_t wdata; // lanes already rotated
  } bus_req_t;

  // response, one per grant, in grant order (33 bits)
  typedef struct packed {
    bus_data_t rdata;
    logic      err;
  } bus_rsp_t;

endpackage

`default_nettype wire

// ==== logic/lsu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// load/store unit core-side types
// access size, unit state, core request and response
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

  // access size as issued by the core
  typedef enum logic [1:0] {
    LSU_SIZE_WORD = 2'b00,
    LSU_SIZE_HALF = 2'b01,
    LSU_SIZE_BYTE = 2'b10
  } lsu_size_e;

  // access state machine
  typedef enum logic [2:0] {
    ST_IDLE,                      // waiting for a core strobe
    ST_WAIT_GNT,                  // single part, or second part after first rvalid
    ST_WAIT_GNT_SPLIT,            // first part of a split access
    ST_WAIT_RVALID_SPLIT,         // second part pending, first response outstanding
    ST_WAIT_RVALID_SPLIT_GNTS_DONE, // both granted, first response outstanding
    ST_WAIT_RVALID                // last response outstanding
  } lsu_state_e;

  // one core access, 68 bits
  typedef struct packed {
    logic                   we;       // store when set
    lsu_size_e              size;
    logic                   sign_ext; // loads only
    logic [`LSU_ADDR_W-1:0] addr;     // byte address, may be unaligned
    logic [`LSU_DATA_W-1:0] wdata;    // right aligned store data
  } lsu_req_t;

  // one core response, 66 bits
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] rdata;     // aligned and extended load data
    logic                   load_err;
    logic                   store_err;
    logic [`LSU_ADDR_W-1:0] err_addr;  // first failing part
  } lsu_resp_t;

endpackage

`default_nettype wire

// ==== include/lsu_settings.svh ====
//////////////////////////////////////////////////////////////////////
// load/store unit settings
// address, data and byte-enable widths, bus outstanding limit
//////////////////////////////////////////////////////////////////////

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// core and bus address width
`define LSU_ADDR_W 32

// data word width, same on core and bus side
`define LSU_DATA_W 32

`define LSU_BE_W (`LSU_DATA_W / 8) // one enable per byte lane

// granted bus requests still waiting for a response
`define LSU_MAX_OUTSTANDING 2

`endif
